// File: logic/fma16_pkg.sv
`default_nettype none

package fma16_pkg;

    //////////////////// format constants
    localparam int BIAS   = 15;
    localparam int EXP_W  = 5;
    localparam int MANT_W = 10;

    localparam int VEC_SIZE_MIN = 74;   // narrowest alignment vector that keeps the sum exact
    localparam int SM_W_MAX     = 128;  // room for the sum magnitude in the stage-2 struct

    // binary16 fields
    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [MANT_W-1:0] mant;
    } fp16_fields_t;

    // one binary16 word, raw or split into fields
    typedef union packed {
        logic [15:0]  bits;
        fp16_fields_t f;
    } fp16_u;

    typedef struct packed {
        fp16_u x;
        fp16_u y;
        fp16_u z;
    } fma16_op_t;

    typedef struct packed {
        fp16_u result;
        logic  inexact;
        logic  overflow;
    } fma16_res_t;

    //////////////////// pipeline stages
    typedef struct packed {
        logic              valid;
        logic              ps;       // product sign
        logic              xs, ys;
        logic signed [6:0] pe;       // xe+ye-bias
        logic [21:0]       mid_pm;   // exact 11x11 product
        logic              zs;
        logic [4:0]        ze;       // subnormal already moved to 1
        logic [10:0]       zm;       // with hidden bit
        logic              x_zero, y_zero, z_zero;
    } prod_stage_t;

    typedef struct packed {
        logic                valid;
        logic                ms;        // result sign
        logic [SM_W_MAX-1:0] sm;        // low VEC_SIZE bits hold the magnitude
        logic                sticky;
        logic [7:0]          m_shift;   // left shift to bring the leading one to the top
        logic [6:0]          base_exp;  // biased exponent before m_shift is taken off
        logic                zero;
    } sum_stage_t;

endpackage

`default_nettype wire

// File: logic/fma16_credit_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module fma16_credit_ctrl #(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_CREDITS = 4
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    input  fma16_pkg::fma16_op_t in_op,
    output logic                 in_credit,
    input  logic                 out_credit,
    output logic                 launch,
    output fma16_pkg::fma16_op_t launch_op
);

    localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int CNT_W = $clog2(IN_DEPTH + 1);
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    fma16_pkg::fma16_op_t queue [IN_DEPTH];  // op storage, no reset needed
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count;                 // entries held
    logic [CRD_W-1:0] credits;               // output slots granted by the receiver

    // head leaves as soon as there is somewhere to put its result
    assign launch    = (count != '0) && (credits != '0);
    assign launch_op = queue[rd_ptr];
    assign in_credit = launch;               // one credit back per departure

    always_ff @(posedge clk) begin
        if (in_valid)
            queue[wr_ptr] <= in_op;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= '0;
        end else begin
            if (in_valid)
                wr_ptr <= (wr_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (launch)
                rd_ptr <= (rd_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

            // sender never overruns, so no full check here
            if (in_valid && !launch)
                count <= count + 1'b1;
            else if (!in_valid && launch)
                count <= count - 1'b1;

            // saturating credit counter
            if (out_credit && !launch && credits < CRD_W'(OUT_CREDITS))
                credits <= credits + 1'b1;
            else if (launch && !out_credit)
                credits <= credits - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/fma16_unpack_mult.sv
`timescale 1ns/10ps
`default_nettype none

module fma16_unpack_mult (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   launch,
    input  fma16_pkg::fma16_op_t   launch_op,
    output fma16_pkg::prod_stage_t prod
);

    fma16_pkg::prod_stage_t prod_d;
    logic       x_sub, y_sub, z_sub;   // exponent field zero
    logic [4:0] xe, ye;                // effective exponents
    logic [10:0] xm, ym;               // mantissas with hidden bit

    //////////////////// decode
    assign x_sub = (launch_op.x.f.exp == '0);
    assign y_sub = (launch_op.y.f.exp == '0);
    assign z_sub = (launch_op.z.f.exp == '0);

    assign xe = x_sub ? 5'd1 : launch_op.x.f.exp;  // subnormal scale is 2^(1-bias)
    assign ye = y_sub ? 5'd1 : launch_op.y.f.exp;
    assign xm = {~x_sub, launch_op.x.f.mant};
    assign ym = {~y_sub, launch_op.y.f.mant};

    always_comb begin
        prod_d        = '0;
        prod_d.valid  = launch;
        prod_d.xs     = launch_op.x.f.sign;
        prod_d.ys     = launch_op.y.f.sign;
        prod_d.ps     = launch_op.x.f.sign ^ launch_op.y.f.sign;
        prod_d.mid_pm = xm * ym;   // exact, at most 22 bits
        // 7 bits signed since xe+ye-bias spans -13..45
        prod_d.pe     = signed'({2'b00, xe} + {2'b00, ye} - 7'(fma16_pkg::BIAS));
        prod_d.zs     = launch_op.z.f.sign;
        prod_d.ze     = z_sub ? 5'd1 : launch_op.z.f.exp;
        prod_d.zm     = {~z_sub, launch_op.z.f.mant};
        prod_d.x_zero = x_sub && (launch_op.x.f.mant == '0);
        prod_d.y_zero = y_sub && (launch_op.y.f.mant == '0);
        prod_d.z_zero = z_sub && (launch_op.z.f.mant == '0);
    end

    //////////////////// stage 1 register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            prod <= '0;
        else
            prod <= prod_d;
    end

endmodule

`default_nettype wire

// File: logic/fma16_sum.sv
`timescale 1ns/10ps
`default_nettype none

module fma16_sum #(
    parameter int VEC_SIZE = 74
) (
    input  logic [VEC_SIZE-1:0] am,          // aligned z
    input  logic [VEC_SIZE-1:0] pm,          // aligned product
    input  logic                sticky_in,   // z lost bits below the vector
    input  logic                diff_sign,
    output logic [VEC_SIZE-1:0] sm,
    output logic                sticky,
    output logic                pm_greater
);

    assign pm_greater = (pm > am);
    assign sticky     = sticky_in;

    always_comb begin
        if (!diff_sign)
            sm = am + pm;   // top bit left free for the carry
        else if (pm_greater)
            // z is the smaller one when it lost bits, so the true difference
            // lies just under pm-am; borrow one and let sticky carry the rest
            sm = pm - am - {{(VEC_SIZE-1){1'b0}}, sticky_in};
        else
            sm = am - pm;
    end

endmodule

`default_nettype wire

// File: logic/fma16_mshifter.sv
`timescale 1ns/10ps
`default_nettype none

module fma16_mshifter #(
    parameter int VEC_SIZE = 74
) (
    input  logic [VEC_SIZE-1:0] sm,
    output logic [7:0]          m_shift,
    output logic                sum_zero
);

    assign sum_zero = (sm == '0);

    // priority scan, highest set bit wins
    always_comb begin
        m_shift = '0;
        for (int i = 0; i < VEC_SIZE; i++) begin
            if (sm[i])
                m_shift = 8'(VEC_SIZE - 1 - i);
        end
    end

endmodule

`default_nettype wire

// File: logic/fma16_align_and_sum.sv
`timescale 1ns/10ps
`default_nettype none

module fma16_align_and_sum #(
    parameter int VEC_SIZE = 74
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  fma16_pkg::prod_stage_t prod,
    output fma16_pkg::sum_stage_t  sum
);

    // product lsb sits at P0, z lsb at P0+10-(pe-ze)
    localparam int P0   = VEC_SIZE - 65;
    localparam int ZOFF = P0 + 10 + 32;   // 32 spare bits below the vector catch shifted-out z

    logic [9:0]            z_shamt;       // always positive for VEC_SIZE >= 74
    logic [VEC_SIZE+31:0]  z_wide;
    logic [VEC_SIZE-1:0]   am, pm, sm;
    logic                  z_lost;        // z bits fell below the vector
    logic                  diff_sign;
    logic                  sticky, pm_greater;
    logic [7:0]            m_shift;
    logic                  sum_zero;
    logic                  prod_zero;
    fma16_pkg::sum_stage_t sum_d;

    //////////////////// alignment
    assign z_shamt = 10'(ZOFF) + {5'b0, prod.ze} - {{3{prod.pe[6]}}, prod.pe};
    assign z_wide  = {{(VEC_SIZE+21){1'b0}}, prod.zm} << z_shamt;
    assign am      = z_wide[VEC_SIZE+31:32];
    assign z_lost  = |z_wide[31:0];

    assign prod_zero = prod.x_zero | prod.y_zero;
    assign pm = prod_zero ? '0 : ({{(VEC_SIZE-22){1'b0}}, prod.mid_pm} << P0);

    assign diff_sign = ~prod.z_zero & (prod.zs ^ prod.ps);   // effective subtraction

    fma16_sum #(.VEC_SIZE(VEC_SIZE)) u_sum (
        .am         (am),
        .pm         (pm),
        .sticky_in  (z_lost),
        .diff_sign  (diff_sign),
        .sm         (sm),
        .sticky     (sticky),
        .pm_greater (pm_greater)
    );

    fma16_mshifter #(.VEC_SIZE(VEC_SIZE)) u_mshifter (
        .sm       (sm),
        .m_shift  (m_shift),
        .sum_zero (sum_zero)
    );

    always_comb begin
        sum_d                    = '0;
        sum_d.valid              = prod.valid;
        sum_d.sm[VEC_SIZE-1:0]   = sm;
        sum_d.sticky             = sticky;
        sum_d.m_shift            = m_shift;
        sum_d.base_exp           = 7'(prod.pe + 7'sd44);   // leading one at top, zero shift
        sum_d.zero               = sum_zero;
        // sign: larger magnitude wins
        if (sum_zero)
            sum_d.ms = prod_zero & prod.z_zero & prod.ps & prod.zs;   // -0 + -0 only
        else if (diff_sign)
            sum_d.ms = pm_greater ? prod.ps : prod.zs;
        else
            sum_d.ms = prod.ps;   // signs agree, or z is zero
    end

    //////////////////// stage 2 register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            sum <= '0;
        else
            sum <= sum_d;
    end

endmodule

`default_nettype wire

// File: logic/fma16_round.sv
`timescale 1ns/10ps
`default_nettype none

module fma16_round #(
    parameter int VEC_SIZE = 74
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  fma16_pkg::sum_stage_t sum,
    output logic                  out_valid,
    output fma16_pkg::fma16_res_t out_res
);

    logic [VEC_SIZE-1:0]   sm;
    logic signed [9:0]     e_norm;       // biased exponent once normalized
    logic                  norm_ok;      // result is a normal number
    logic [7:0]            shift;
    logic [VEC_SIZE-1:0]   n;            // normalized vector
    logic [6:0]            e_field;
    logic                  guard, rest, lsb, up;
    logic [16:0]           packed_w;     // exponent and mantissa after rounding
    logic                  ovf, inexact;
    fma16_pkg::fma16_res_t res_d;

    assign sm = sum.sm[VEC_SIZE-1:0];

    //////////////////// normalize
    assign e_norm  = signed'({3'b000, sum.base_exp}) - signed'({2'b00, sum.m_shift});
    assign norm_ok = (e_norm >= 10'sd1);
    // subnormal results stop at exponent 1
    assign shift   = norm_ok ? sum.m_shift : 8'(sum.base_exp - 7'd1);
    assign n       = sm << shift;
    assign e_field = n[VEC_SIZE-1] ? e_norm[6:0] : 7'd0;

    //////////////////// round to nearest even
    assign guard = n[VEC_SIZE-12];
    assign rest  = (|n[VEC_SIZE-13:0]) | sum.sticky;
    assign lsb   = n[VEC_SIZE-11];
    assign up    = guard & (rest | lsb);

    // carry out of the mantissa lands in the exponent
    assign packed_w = {e_field, n[VEC_SIZE-2:VEC_SIZE-11]} + 17'(up);
    assign ovf      = (packed_w[16:10] >= 7'd31);
    assign inexact  = guard | rest | ovf;

    always_comb begin
        res_d          = '0;
        res_d.inexact  = inexact;
        res_d.overflow = ovf;
        if (sum.zero && !sum.sticky) begin
            res_d.result.bits = {sum.ms, 15'd0};   // sign already resolved upstream
            res_d.inexact     = 1'b0;
            res_d.overflow    = 1'b0;
        end else if (ovf) begin
            res_d.result.f.sign = sum.ms;
            res_d.result.f.exp  = '1;              // infinity
            res_d.result.f.mant = '0;
        end else begin
            res_d.result.bits = {sum.ms, packed_w[14:0]};
        end
    end

    //////////////////// stage 3 register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            out_res   <= '0;
        end else begin
            out_valid <= sum.valid;
            out_res   <= res_d;
        end
    end

endmodule

`default_nettype wire

// File: logic/fma16_top.sv
`timescale 1ns/10ps
`default_nettype none

module fma16_top #(
    parameter int VEC_SIZE    = 74,
    parameter int IN_DEPTH    = 4,
    parameter int OUT_CREDITS = 4
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_valid,
    input  fma16_pkg::fma16_op_t  in_op,
    output logic                  in_credit,
    output logic                  out_valid,
    output fma16_pkg::fma16_res_t out_res,
    input  logic                  out_credit
);

    logic                   launch;
    fma16_pkg::fma16_op_t   launch_op;
    fma16_pkg::prod_stage_t prod;
    fma16_pkg::sum_stage_t  sum;

    fma16_credit_ctrl #(
        .IN_DEPTH    (IN_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_credit_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .launch     (launch),
        .launch_op  (launch_op)
    );

    fma16_unpack_mult u_unpack_mult (
        .clk       (clk),
        .arst_n    (arst_n),
        .launch    (launch),
        .launch_op (launch_op),
        .prod      (prod)
    );

    fma16_align_and_sum #(.VEC_SIZE(VEC_SIZE)) u_align_and_sum (
        .clk    (clk),
        .arst_n (arst_n),
        .prod   (prod),
        .sum    (sum)
    );

    fma16_round #(.VEC_SIZE(VEC_SIZE)) u_round (
        .clk       (clk),
        .arst_n    (arst_n),
        .sum       (sum),
        .out_valid (out_valid),
        .out_res   (out_res)
    );

endmodule

`default_nettype wire

// File: tests/fma16_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module fma16_assertions #(
    parameter int IN_DEPTH = 4
) (
    input logic clk,
    input logic arst_n,
    input logic in_valid,
    input logic in_credit,
    input logic launch,
    input logic out_valid
);

    int occupancy;   // queue entries, rebuilt from accepts and launches

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            occupancy <= 0;
        else
            occupancy <= occupancy + int'(in_valid) - int'(launch);
    end

    //////////////////// pipeline timing
    a_launch_to_out: assert property (@(posedge clk) disable iff (!arst_n)
        $past(launch, 3) |-> out_valid)
        else $error("launch not followed by out_valid three cycles later");

    a_out_from_launch: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> $past(launch, 3))
        else $error("out_valid without a launch three cycles earlier");

    //////////////////// credit protocol
    a_no_overrun: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid |-> occupancy < IN_DEPTH)
        else $error("in_valid while the input queue is full");

    a_quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> !in_credit && !out_valid)
        else $error("in_credit or out_valid active during reset");

endmodule

bind fma16_top fma16_assertions #(.IN_DEPTH(IN_DEPTH)) u_assertions (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_credit (in_credit),
    .launch    (launch),
    .out_valid (out_valid)
);

`default_nettype wire

// File: include/fma16_ref_model.svh
`ifndef FMA16_REF_MODEL_SVH
`define FMA16_REF_MODEL_SVH
`default_nettype none

// exact x*y+z in units of 2^-48, then one rounding to nearest even
function automatic fma16_pkg::fma16_res_t fma16_ref(input fma16_pkg::fp16_u x,
                                                    input fma16_pkg::fp16_u y,
                                                    input fma16_pkg::fp16_u z);
    fma16_pkg::fma16_res_t res;
    int          xe, ye, ze, lead, e, sh;
    logic [10:0] xm, ym, zm;
    logic [95:0] p, zz, a, rem, half, q, pk;
    logic        ps, rs, up;

    xe = (x.f.exp == 0) ? 1 : x.f.exp;
    ye = (y.f.exp == 0) ? 1 : y.f.exp;
    ze = (z.f.exp == 0) ? 1 : z.f.exp;
    xm = {x.f.exp != 0, x.f.mant};
    ym = {y.f.exp != 0, y.f.mant};
    zm = {z.f.exp != 0, z.f.mant};
    ps = x.f.sign ^ y.f.sign;
    p  = (96'(xm) * 96'(ym)) << (xe + ye - 2);   // product lsb weight 2^(xe+ye-50)
    zz = 96'(zm) << (ze + 23);            // z lsb weight 2^(ze-25)
    res = '0;

    // signed magnitude sum
    if (ps == z.f.sign) begin
        a  = p + zz;
        rs = ps;
    end else if (p > zz) begin
        a  = p - zz;
        rs = ps;
    end else begin
        a  = zz - p;
        rs = z.f.sign;
    end

    if (a == 0) begin
        // -0 only when both addends are negative zeros
        res.result.bits = {(p == 0) && (zz == 0) && ps && z.f.sign, 15'd0};
        return res;
    end

    lead = 0;
    for (int i = 0; i < 96; i++) begin
        if (a[i])
            lead = i;
    end
    e  = lead - 33;                       // biased exponent of the leading one
    sh = (e < 1) ? 24 : lead - 10;        // weight of the result lsb
    q    = a >> sh;
    rem  = a & ((96'd1 << sh) - 1);
    half = 96'd1 << (sh - 1);
    up   = (rem > half) || ((rem == half) && q[0]);
    q    = q + 96'(up);
    pk   = (e < 1) ? q : ((96'(e - 1) << 10) + q);

    res.inexact = (rem != 0);
    if (pk >= 96'(31 << 10)) begin
        res.result.bits = {rs, 5'h1f, 10'd0};
        res.overflow    = 1'b1;
        res.inexact     = 1'b1;
    end else begin
        res.result.bits = {rs, pk[14:0]};
    end
    return res;
endfunction

`default_nettype wire
`endif

// File: tests/fma16_tb.sv
`timescale 1ns/10ps
`include "fma16_ref_model.svh"
`default_nettype none

module fma16_tb;

    localparam int IN_DEPTH    = 4;
    localparam int OUT_CREDITS = 4;
    localparam int N_RANDOM    = 2000;
    localparam int N_CREDIT    = 300;

    logic                  clk;
    logic                  arst_n;
    logic                  in_valid;
    fma16_pkg::fma16_op_t  in_op;
    logic                  in_credit;
    logic                  out_valid;
    fma16_pkg::fma16_res_t out_res;
    logic                  out_credit;

    integer                seed = 32'h20a9_8c87;
    fma16_pkg::fma16_op_t  stim_op[$];
    string                 stim_name[$];
    fma16_pkg::fma16_res_t exp_q[$];       // expected results in issue order
    string                 exp_name_q[$];
    int                    credit_start;   // first op of the stall phase
    int                    send_idx;
    int                    send_credits;   // sender side, one per free queue entry
    int                    rx_slots;       // receiver slots granted and not yet filled
    int                    rcv_cnt;
    int                    cycle_cnt = 0;
    int                    timeout_limit = 100000;

    fma16_top #(
        .VEC_SIZE    (74),
        .IN_DEPTH    (IN_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) fma16_top_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_res    (out_res),
        .out_credit (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic add_op(input string name, input logic [15:0] x, y, z);
        fma16_pkg::fma16_op_t op;
        op.x.bits = x;
        op.y.bits = y;
        op.z.bits = z;
        stim_op.push_back(op);
        stim_name.push_back(name);
    endtask

    function automatic fma16_pkg::fp16_u random_fp16();
        fma16_pkg::fp16_u v;
        v.bits = 16'($random(seed));
        if (v.f.exp == 5'h1f)
            v.f.exp = 5'h00;   // inf/nan codes become subnormals
        return v;
    endfunction

    //////////////////// stimulus
    task automatic build_stimulus();
        fma16_pkg::fp16_u      x, y, z, zero_w;
        fma16_pkg::fma16_res_t p;
        zero_w.bits = 16'h0000;
        add_op("exact", 16'h3e00, 16'h4000, 16'h3400);     // 1.5*2+0.25
        add_op("exact", 16'h0000, 16'h4500, 16'h3c00);     // zero x, nonzero z
        add_op("exact", 16'h3c00, 16'h3c00, 16'h3c00);
        add_op("exact", 16'hc000, 16'h3800, 16'h4200);     // -2*0.5+3
        add_op("exact", 16'h8000, 16'h3c00, 16'h8000);     // -0 plus -0
        add_op("exact", 16'h4400, 16'h0000, 16'h0000);
        add_op("cancel", 16'h3e00, 16'h4000, 16'hc200);    // 3-3 gives +0
        add_op("cancel", 16'h3c01, 16'h3c01, 16'hbc02);    // leaves 2^-20
        add_op("cancel", 16'h3bff, 16'h3c01, 16'hbc00);
        add_op("round", 16'h3c00, 16'h3c00, 16'h1000);     // tie, stays even
        add_op("round", 16'h3c00, 16'h3c00, 16'h1600);     // tie, rounds up to even
        add_op("round", 16'h3c01, 16'h3c01, 16'h0000);
        add_op("round", 16'h0001, 16'h3c00, 16'h0001);     // subnormal in and out
        add_op("round", 16'h0200, 16'h0200, 16'h0000);     // far below min step
        add_op("round", 16'h0300, 16'h3800, 16'h8001);
        add_op("round", 16'h1400, 16'h0a00, 16'h0000);
        add_op("round", 16'h0400, 16'h3bff, 16'h0000);     // rounds up into min normal
        add_op("overflow", 16'h7bff, 16'h4000, 16'h0000);
        add_op("overflow", 16'hfbff, 16'h7bff, 16'h3c00);  // negative infinity
        add_op("overflow", 16'h7bff, 16'h3c00, 16'h4c00);  // tie at max goes to inf
        add_op("overflow", 16'h7bff, 16'h3c00, 16'h4bff);  // just below, stays finite
        for (int i = 0; i < N_RANDOM; i++) begin
            x = random_fp16();
            y = random_fp16();
            z = random_fp16();
            if (i % 4 == 0) begin
                // z close to -x*y for deep cancellation
                p = fma16_ref(x, y, zero_w);
                if (p.result.f.exp != 5'h1f)
                    z.bits = p.result.bits ^ 16'h8000 ^ (z.bits & 16'h0003);
            end
            add_op("random", x.bits, y.bits, z.bits);
        end
        credit_start = stim_op.size();
        for (int i = 0; i < N_CREDIT; i++) begin
            x = random_fp16();
            y = random_fp16();
            z = random_fp16();
            add_op("credit", x.bits, y.bits, z.bits);
        end
    endtask

    //////////////////// credit models
    task automatic drive_sender();
        fma16_pkg::fma16_op_t op;
        if (in_credit)
            send_credits++;
        assert (send_credits <= IN_DEPTH)
            else abort_run("in_credit returned more credits than the sender spent");
        if (send_idx < stim_op.size() && send_credits > 0 && ($random(seed) & 3) != 0) begin
            op = stim_op[send_idx];
            in_valid <= 1'b1;
            in_op    <= op;
            exp_q.push_back(fma16_ref(op.x, op.y, op.z));
            exp_name_q.push_back(stim_name[send_idx]);
            send_idx++;
            send_credits--;
        end else begin
            in_valid <= 1'b0;
        end
    endtask

    task automatic drive_receiver();
        logic hold;
        if (out_valid) begin
            assert (rx_slots > 0)
                else abort_run("out_valid arrived without a granted output credit");
            rx_slots--;
        end
        // long stretches without credits once the stall phase starts
        hold = (send_idx >= credit_start) && ((cycle_cnt % 160) < 110);
        if (!hold && rx_slots < OUT_CREDITS && ($random(seed) & 3) != 0) begin
            out_credit <= 1'b1;
            rx_slots++;
        end else begin
            out_credit <= 1'b0;
        end
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            in_valid   <= 1'b0;
            out_credit <= 1'b0;
        end else begin
            drive_sender();
            drive_receiver();
        end
    end

    //////////////////// scoreboard
    always @(posedge clk) begin
        fma16_pkg::fma16_res_t exp_res;
        string                 name;
        if (arst_n && out_valid) begin
            assert (exp_q.size() > 0)
                else abort_run("out_valid arrived with no operation outstanding");
            exp_res = exp_q.pop_front();
            name    = exp_name_q.pop_front();
            assert (out_res == exp_res) else begin
                $display("** Error [%s] expected %h nx %b ovf %b, actual %h nx %b ovf %b",
                         name, exp_res.result.bits, exp_res.inexact, exp_res.overflow,
                         out_res.result.bits, out_res.inexact, out_res.overflow);
                $display("SOME TESTS FAILED");
                $fatal(1, "result mismatch");
            end
            rcv_cnt++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > timeout_limit)
            abort_run($sformatf("timeout after %0d cycles, results stopped arriving",
                                cycle_cnt));
    end

    initial begin
        arst_n       = 1'b0;
        in_valid     = 1'b0;
        in_op        = '0;
        out_credit   = 1'b0;
        send_idx     = 0;
        send_credits = IN_DEPTH;
        rx_slots     = 0;
        rcv_cnt      = 0;
        build_stimulus();
        timeout_limit = 40 * stim_op.size() + 1000;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        wait (rcv_cnt == stim_op.size());
        repeat (10) @(posedge clk);   // a stray result would show up here
        if (send_credits == IN_DEPTH) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("input credits were not all returned after the last result");
            $display("SOME TESTS FAILED");
            $fatal(1, "credit count mismatch");
        end
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
logic/fma16_pkg.sv
logic/fma16_credit_ctrl.sv
logic/fma16_unpack_mult.sv
logic/fma16_sum.sv
logic/fma16_mshifter.sv
logic/fma16_align_and_sum.sv
logic/fma16_round.sv
logic/fma16_top.sv
tests/fma16_assertions.sv
tests/fma16_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= fma16_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
